/* hdl/rvc_pkg.sv */
package rvc_pkg;

    localparam int INST_W = 16;
    localparam int XLEN   = 32;
    localparam int REG_W  = 5;

    localparam logic [REG_W-1:0] REG_ZERO = 5'd0;
    localparam logic [REG_W-1:0] REG_RA   = 5'd1;
    localparam logic [REG_W-1:0] REG_SP   = 5'd2;

    // x8..x15 reachable through the three-bit fields
    localparam logic [REG_W-1:0] COMPACT_REG_BASE = 5'd8;

    localparam logic [1:0] QUAD_0    = 2'd0;
    localparam logic [1:0] QUAD_1    = 2'd1;
    localparam logic [1:0] QUAD_2    = 2'd2;
    localparam logic [1:0] QUAD_FULL = 2'd3; // 32-bit encodings

    typedef enum logic [3:0] {
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,
        ALU_AND = 4'd3,
        ALU_OR  = 4'd4,
        ALU_XOR = 4'd5,
        ALU_SLL = 4'd8,
        ALU_SRL = 4'd9,
        ALU_SRA = 4'd10
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_U = 3'd2,
        IMM_B = 3'd3,
        IMM_J = 3'd4
    } imm_sel_t;

    typedef enum logic [1:0] {
        DATA_PC_LINK = 2'd0,
        DATA_ALU     = 2'd1,
        DATA_IMM     = 2'd2,
        DATA_MEM     = 2'd3
    } data_sel_t;

    typedef enum logic [4:0] {
        K_NONE,
        K_ADDI4SPN, K_LW, K_SW,
        K_ADDI, K_JAL, K_LI, K_LUI, K_ADDI16SP,
        K_SRLI, K_SRAI, K_ANDI, K_SUB, K_XOR, K_OR, K_AND,
        K_J, K_BEQZ, K_BNEZ,
        K_SLLI, K_LWSP, K_SWSP, K_JR, K_JALR, K_MV, K_ADD
    } rvc_kind_t;

    // same 16 bits, CR/CI field split or CA/CB/CL/CS split
    typedef union packed {
        struct packed {
            logic [2:0] funct3;
            logic       funct4;
            logic [4:0] rd_rs1;
            logic [4:0] rs2;
            logic [1:0] opcode;
        } full;
        struct packed {
            logic [2:0] funct3;
            logic       funct4;
            logic [1:0] funct2;
            logic [2:0] rs1c;
            logic [1:0] funct2_lo;
            logic [2:0] rs2c;
            logic [1:0] opcode;
        } compact;
    } rvc_inst_u;

endpackage

/* hdl/rvc_kind_if.sv */
`timescale 1ns/1ps

interface rvc_kind_if import rvc_pkg::*; ();

    rvc_inst_u inst;   // raw word, both views
    rvc_kind_t kind;
    alu_op_t   alu_op;
    logic      valid;

    modport source (
        output inst,
        output kind,
        output alu_op,
        output valid
    );

    modport sink (
        input inst,
        input kind,
        input alu_op,
        input valid
    );

endinterface

/* hdl/rvc_classifier.sv */
`timescale 1ns/1ps

module rvc_classifier import rvc_pkg::*; (
    input  logic [INST_W-1:0] i_inst,
    input  logic              i_valid,
    rvc_kind_if.source        kind_out
);

    rvc_inst_u word;
    logic      ci_imm_zero;   // six-bit CI immediate is zero
    rvc_kind_t kind;
    alu_op_t   alu_op;

    assign word        = i_inst;
    assign ci_imm_zero = ({word.full.funct4, word.full.rs2} == 6'd0);

    always_comb begin
        kind   = K_NONE;
        alu_op = ALU_ADD;
        case (word.full.opcode)
            QUAD_0: begin
                case (word.full.funct3)
                    3'd0: if (i_inst[12:5] != 8'd0) kind = K_ADDI4SPN; // zero offset reserved
                    3'd2: kind = K_LW;
                    3'd6: kind = K_SW;
                    default: kind = K_NONE;
                endcase
            end
            QUAD_1: begin
                case (word.full.funct3)
                    3'd0: kind = K_ADDI;
                    3'd1: kind = K_JAL;
                    3'd2: kind = K_LI;
                    3'd3: begin
                        // rd == sp selects the stack adjust
                        if (!ci_imm_zero) begin
                            kind = (word.full.rd_rs1 == REG_SP) ? K_ADDI16SP : K_LUI;
                        end
                    end
                    3'd4: begin
                        case (word.compact.funct2)
                            2'd0: begin
                                if (!word.compact.funct4) begin // shamt[5] reserved on rv32
                                    kind   = K_SRLI;
                                    alu_op = ALU_SRL;
                                end
                            end
                            2'd1: begin
                                if (!word.compact.funct4) begin
                                    kind   = K_SRAI;
                                    alu_op = ALU_SRA;
                                end
                            end
                            2'd2: begin
                                kind   = K_ANDI;
                                alu_op = ALU_AND;
                            end
                            default: begin
                                if (!word.compact.funct4) begin
                                    case (word.compact.funct2_lo)
                                        2'd0: begin
                                            kind   = K_SUB;
                                            alu_op = ALU_SUB;
                                        end
                                        2'd1: begin
                                            kind   = K_XOR;
                                            alu_op = ALU_XOR;
                                        end
                                        2'd2: begin
                                            kind   = K_OR;
                                            alu_op = ALU_OR;
                                        end
                                        default: begin
                                            kind   = K_AND;
                                            alu_op = ALU_AND;
                                        end
                                    endcase
                                end
                            end
                        endcase
                    end
                    3'd5: kind = K_J;
                    3'd6: begin
                        kind   = K_BEQZ;
                        alu_op = ALU_SUB; // compare against x0
                    end
                    default: begin
                        kind   = K_BNEZ;
                        alu_op = ALU_SUB;
                    end
                endcase
            end
            QUAD_2: begin
                case (word.full.funct3)
                    3'd0: begin
                        if (!word.full.funct4) begin
                            kind   = K_SLLI;
                            alu_op = ALU_SLL;
                        end
                    end
                    3'd2: if (word.full.rd_rs1 != REG_ZERO) kind = K_LWSP;
                    3'd6: kind = K_SWSP;
                    3'd4: begin
                        if (word.full.rs2 != REG_ZERO) begin
                            kind = word.full.funct4 ? K_ADD : K_MV;
                        end else if (word.full.rd_rs1 != REG_ZERO) begin
                            kind = word.full.funct4 ? K_JALR : K_JR;
                        end
                        // rd and rs2 both zero is ebreak or reserved, left as none
                    end
                    default: kind = K_NONE;
                endcase
            end
            default: kind = K_NONE; // full-width word
        endcase
    end

    assign kind_out.inst   = word;
    assign kind_out.kind   = kind;
    assign kind_out.alu_op = alu_op;
    assign kind_out.valid  = i_valid;

endmodule

/* hdl/rvc_reg_select.sv */
`timescale 1ns/1ps

module rvc_reg_select import rvc_pkg::*; (
    rvc_kind_if.sink         kind_in,
    output logic [REG_W-1:0] o_rs1,
    output logic [REG_W-1:0] o_rs2,
    output logic [REG_W-1:0] o_rd
);

    logic [REG_W-1:0] rs1_c;  // expanded rs1'
    logic [REG_W-1:0] rs2_c;  // expanded rs2'
    logic [REG_W-1:0] rd_full;
    logic [REG_W-1:0] rs2_full;

    assign rs1_c    = COMPACT_REG_BASE + {2'b00, kind_in.inst.compact.rs1c};
    assign rs2_c    = COMPACT_REG_BASE + {2'b00, kind_in.inst.compact.rs2c};
    assign rd_full  = kind_in.inst.full.rd_rs1;
    assign rs2_full = kind_in.inst.full.rs2;

    always_comb begin
        o_rs1 = REG_ZERO;
        o_rs2 = REG_ZERO;
        o_rd  = REG_ZERO;
        case (kind_in.kind)
            K_ADDI4SPN: begin
                o_rs1 = REG_SP;
                o_rd  = rs2_c;
            end
            K_LW: begin
                o_rs1 = rs1_c;
                o_rd  = rs2_c;
            end
            K_SW: begin
                o_rs1 = rs1_c;
                o_rs2 = rs2_c;
            end
            K_ADDI, K_SLLI: begin
                o_rs1 = rd_full;
                o_rd  = rd_full;
            end
            K_LI, K_LUI: o_rd = rd_full; // source stays x0
            K_ADDI16SP: begin
                o_rs1 = REG_SP;
                o_rd  = REG_SP;
            end
            K_SRLI, K_SRAI, K_ANDI: begin
                o_rs1 = rs1_c;
                o_rd  = rs1_c;
            end
            K_SUB, K_XOR, K_OR, K_AND: begin
                o_rs1 = rs1_c;
                o_rs2 = rs2_c;
                o_rd  = rs1_c;
            end
            K_BEQZ, K_BNEZ: o_rs1 = rs1_c;
            K_JAL:  o_rd = REG_RA;
            K_LWSP: begin
                o_rs1 = REG_SP;
                o_rd  = rd_full;
            end
            K_SWSP: begin
                o_rs1 = REG_SP;
                o_rs2 = rs2_full;
            end
            K_JR: o_rs1 = rd_full;
            K_JALR: begin
                o_rs1 = rd_full;
                o_rd  = REG_RA;
            end
            K_MV: begin
                o_rs2 = rs2_full;
                o_rd  = rd_full;
            end
            K_ADD: begin
                o_rs1 = rd_full;
                o_rs2 = rs2_full;
                o_rd  = rd_full;
            end
            default: o_rd = REG_ZERO; // J and none
        endcase
    end

endmodule

/* hdl/rvc_imm_gen.sv */
`timescale 1ns/1ps

module rvc_imm_gen import rvc_pkg::*; (
    rvc_kind_if.sink        kind_in,
    output logic [XLEN-1:0] o_imm,
    output logic [XLEN-1:0] o_jt
);

    logic [INST_W-1:0] w;
    logic              sign;
    logic [4:0]        low5;   // CI immediate bits 4:0
    logic [XLEN-1:0]   cj_target;
    logic [XLEN-1:0]   cb_target;

    assign w    = kind_in.inst;
    assign sign = kind_in.inst.full.funct4;
    assign low5 = kind_in.inst.full.rs2;

    // offset[11|4|9:8|10|6|7|3:1|5] sits in bits 12:2
    assign cj_target = {{20{sign}}, sign, w[8], w[10:9], w[6], w[7], w[2], w[11],
                        w[5:3], 1'b0};
    // offset[8|4:3] in 12:10, offset[7:6|2:1|5] in 6:2
    assign cb_target = {{23{sign}}, sign, w[6:5], w[2], w[11:10], w[4:3], 1'b0};

    assign o_jt = (kind_in.kind inside {K_JAL, K_J}) ? cj_target : cb_target;

    always_comb begin
        case (kind_in.kind)
            K_ADDI, K_LI, K_ANDI:
                o_imm = {{27{sign}}, low5};
            K_SRLI, K_SRAI, K_SLLI:
                o_imm = {26'd0, sign, low5};              // shamt, unsigned
            K_LW, K_SW:
                o_imm = {25'd0, w[5], w[12:10], w[6], 2'b00};
            K_LWSP:
                o_imm = {24'd0, w[3:2], w[12], w[6:4], 2'b00};
            K_SWSP:
                o_imm = {24'd0, w[8:7], w[12:9], 2'b00};
            K_ADDI4SPN:
                o_imm = {22'd0, w[10:7], w[12:11], w[5], w[6], 2'b00};
            K_ADDI16SP:
                o_imm = {{22{sign}}, sign, w[4:3], w[5], w[2], w[6], 4'b0000};
            K_LUI:
                o_imm = {{14{sign}}, sign, low5, 12'd0}; // lands in bits 17:12
            default:
                o_imm = '0;
        endcase
    end

endmodule

/* hdl/rvc_decode_stage.sv */
`timescale 1ns/1ps

module rvc_decode_stage import rvc_pkg::*; (
    input  logic             clk,
    input  logic             i_reset,
    rvc_kind_if.sink         kind_in,
    input  logic [REG_W-1:0] i_rs1,
    input  logic [REG_W-1:0] i_rs2,
    input  logic [REG_W-1:0] i_rd,
    input  logic [XLEN-1:0]  i_imm,
    input  logic [XLEN-1:0]  i_jt,
    output logic             o_valid,
    output logic             o_is_compressed,
    output alu_op_t          o_alu_op,
    output imm_sel_t         o_imm_select,
    output data_sel_t        o_sel_data,
    output logic             o_sel_op_a,
    output logic             o_sel_op_b,
    output logic             o_is_stype,
    output logic             o_is_load,
    output logic             o_wr_en,
    output logic [1:0]       o_btype,
    output logic             o_use_a,
    output logic             o_use_b,
    output logic             o_is_jump,
    output logic             o_is_btype,
    output logic [REG_W-1:0] o_rs1,
    output logic [REG_W-1:0] o_rs2,
    output logic [REG_W-1:0] o_rd,
    output logic [XLEN-1:0]  o_imm,
    output logic [XLEN-1:0]  o_jt
);

    rvc_kind_t kind;
    logic      is_jump, is_btype, is_stype, is_load, is_link, is_lui, is_rr;
    logic      wr_en;
    imm_sel_t  imm_select;
    data_sel_t sel_data;

    assign kind     = kind_in.kind;
    assign is_jump  = kind inside {K_JAL, K_J, K_JR, K_JALR};
    assign is_btype = kind inside {K_BEQZ, K_BNEZ};
    assign is_stype = kind inside {K_SW, K_SWSP};
    assign is_load  = kind inside {K_LW, K_LWSP};
    assign is_link  = kind inside {K_JR, K_JALR};   // register-indirect jumps
    assign is_lui   = (kind == K_LUI);
    assign is_rr    = kind inside {K_SUB, K_XOR, K_OR, K_AND, K_MV, K_ADD};
    assign wr_en    = !(kind inside {K_NONE, K_JR}) && !is_stype && !is_btype;

    always_comb begin
        if (is_jump)       imm_select = IMM_J;
        else if (is_btype) imm_select = IMM_B;
        else if (is_lui)   imm_select = IMM_U;
        else if (is_stype) imm_select = IMM_S;
        else               imm_select = IMM_I;
    end

    always_comb begin
        if (is_link)      sel_data = DATA_PC_LINK;
        else if (is_lui)  sel_data = DATA_IMM;
        else if (is_load) sel_data = DATA_MEM;
        else              sel_data = DATA_ALU;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid         <= 1'b0;
            o_is_compressed <= 1'b0;
            o_alu_op        <= alu_op_t'(4'd0);
            o_imm_select    <= IMM_I;
            o_sel_data      <= DATA_PC_LINK;
            o_sel_op_a      <= 1'b0;
            o_sel_op_b      <= 1'b0;
            o_is_stype      <= 1'b0;
            o_is_load       <= 1'b0;
            o_wr_en         <= 1'b0;
            o_btype         <= 2'b00;
            o_use_a         <= 1'b0;
            o_use_b         <= 1'b0;
            o_is_jump       <= 1'b0;
            o_is_btype      <= 1'b0;
            o_rs1           <= '0;
            o_rs2           <= '0;
            o_rd            <= '0;
            o_imm           <= '0;
            o_jt            <= '0;
        end else begin
            o_valid <= kind_in.valid;  // drops on an idle cycle
            if (kind_in.valid) begin
                o_is_compressed <= (kind_in.inst.full.opcode != QUAD_FULL);
                o_alu_op        <= kind_in.alu_op;
                o_imm_select    <= imm_select;
                o_sel_data      <= sel_data;
                o_sel_op_a      <= !(is_lui || is_link);
                o_sel_op_b      <= !(is_rr || is_btype);
                o_is_stype      <= is_stype;
                o_is_load       <= is_load;
                o_wr_en         <= wr_en;
                o_btype         <= {kind == K_BEQZ, kind == K_BNEZ};
                o_use_a         <= (i_rs1 != REG_ZERO);
                o_use_b         <= (i_rs2 != REG_ZERO);
                o_is_jump       <= is_jump;
                o_is_btype      <= is_btype;
                o_rs1           <= i_rs1;
                o_rs2           <= i_rs2;
                o_rd            <= i_rd;
                o_imm           <= i_imm;
                o_jt            <= i_jt;
            end
        end
    end

endmodule

/* hdl/rvc_decoder_top.sv */
`timescale 1ns/1ps

module rvc_decoder_top import rvc_pkg::*; (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_valid,
    input  logic [INST_W-1:0] i_inst,
    output logic              o_valid,
    output logic              o_is_compressed,
    output alu_op_t           o_alu_op,
    output imm_sel_t          o_imm_select,
    output data_sel_t         o_sel_data,
    output logic              o_sel_op_a,
    output logic              o_sel_op_b,
    output logic              o_is_stype,
    output logic              o_is_load,
    output logic              o_wr_en,
    output logic [1:0]        o_btype,
    output logic              o_use_a,
    output logic              o_use_b,
    output logic              o_is_jump,
    output logic              o_is_btype,
    output logic [REG_W-1:0]  o_rs1,
    output logic [REG_W-1:0]  o_rs2,
    output logic [REG_W-1:0]  o_rd,
    output logic [XLEN-1:0]   o_imm,
    output logic [XLEN-1:0]   o_jt
);

    rvc_kind_if kind_bus ();

    logic [REG_W-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]  imm, jt;

    rvc_classifier rvc_classifier_inst (
        .i_inst   (i_inst),
        .i_valid  (i_valid),
        .kind_out (kind_bus.source)
    );

    // register and immediate paths run side by side
    rvc_reg_select rvc_reg_select_inst (
        .kind_in (kind_bus.sink),
        .o_rs1   (rs1),
        .o_rs2   (rs2),
        .o_rd    (rd)
    );

    rvc_imm_gen rvc_imm_gen_inst (
        .kind_in (kind_bus.sink),
        .o_imm   (imm),
        .o_jt    (jt)
    );

    rvc_decode_stage rvc_decode_stage_inst (
        .clk             (clk),
        .i_reset         (i_reset),
        .kind_in         (kind_bus.sink),
        .i_rs1           (rs1),
        .i_rs2           (rs2),
        .i_rd            (rd),
        .i_imm           (imm),
        .i_jt            (jt),
        .o_valid         (o_valid),
        .o_is_compressed (o_is_compressed),
        .o_alu_op        (o_alu_op),
        .o_imm_select    (o_imm_select),
        .o_sel_data      (o_sel_data),
        .o_sel_op_a      (o_sel_op_a),
        .o_sel_op_b      (o_sel_op_b),
        .o_is_stype      (o_is_stype),
        .o_is_load       (o_is_load),
        .o_wr_en         (o_wr_en),
        .o_btype         (o_btype),
        .o_use_a         (o_use_a),
        .o_use_b         (o_use_b),
        .o_is_jump       (o_is_jump),
        .o_is_btype      (o_is_btype),
        .o_rs1           (o_rs1),
        .o_rs2           (o_rs2),
        .o_rd            (o_rd),
        .o_imm           (o_imm),
        .o_jt            (o_jt)
    );

endmodule

/* tests/rvc_decoder_assertions.sv */
`timescale 1ns/1ps

module rvc_decoder_assertions import rvc_pkg::*; (
    input logic       clk,
    input logic       i_reset,
    input logic       i_valid,       // registered outputs of the decode stage
    input logic       i_wr_en,
    input logic       i_is_stype,
    input logic       i_is_btype,
    input logic       i_is_jump,
    input imm_sel_t   i_imm_select,
    input logic [1:0] i_btype
);

    // stores and branches never write back
    no_write_on_store_or_branch: assert property (@(posedge clk) disable iff (i_reset)
        !(i_wr_en && (i_is_stype || i_is_btype)))
        else $error("write enable high together with a store or branch");

    jump_uses_j_immediate: assert property (@(posedge clk) disable iff (i_reset)
        i_is_jump |-> (i_imm_select == IMM_J))
        else $error("jump without the J immediate select");

    // first cycle out of reset
    valid_low_after_reset: assert property (@(posedge clk)
        i_reset |=> !i_valid)
        else $error("valid high in the cycle after reset");

    btype_matches_branch_flag: assert property (@(posedge clk) disable iff (i_reset)
        (i_btype != 2'b00) == i_is_btype)
        else $error("branch type and branch flag disagree");

endmodule

/* tests/tb_rvc_decoder.sv */
`timescale 1ns/1ps

module tb_rvc_decoder import rvc_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_WORDS   = 16;

    typedef struct packed {
        logic              full;   // 32-bit opcode with only a few defined outputs
        logic [INST_W-1:0] inst;
        rvc_kind_t         kind;
        alu_op_t           alu;
        logic [REG_W-1:0]  rs1;
        logic [REG_W-1:0]  rs2;
        logic [REG_W-1:0]  rd;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   jt;
    } row_t;

    logic              clk;
    logic              i_reset;
    logic              i_valid;
    logic [INST_W-1:0] i_inst;
    logic              o_valid, o_is_compressed;
    alu_op_t           o_alu_op;
    imm_sel_t          o_imm_select;
    data_sel_t         o_sel_data;
    logic              o_sel_op_a, o_sel_op_b, o_is_stype, o_is_load, o_wr_en;
    logic [1:0]        o_btype;
    logic              o_use_a, o_use_b, o_is_jump, o_is_btype;
    logic [REG_W-1:0]  o_rs1, o_rs2, o_rd;
    logic [XLEN-1:0]   o_imm, o_jt;

    row_t tbl[$];
    logic table_built;

    rvc_decoder_top rvc_decoder_top_inst (.*);

    bind rvc_decode_stage rvc_decoder_assertions rvc_decoder_assertions_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_valid      (o_valid),
        .i_wr_en      (o_wr_en),
        .i_is_stype   (o_is_stype),
        .i_is_btype   (o_is_btype),
        .i_is_jump    (o_is_jump),
        .i_imm_select (o_imm_select),
        .i_btype      (o_btype)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_row(input logic [INST_W-1:0] inst, input rvc_kind_t kind,
                           input alu_op_t alu, input logic [REG_W-1:0] rs1,
                           input logic [REG_W-1:0] rs2, input logic [REG_W-1:0] rd,
                           input logic [XLEN-1:0] imm, input logic [XLEN-1:0] jt);
        row_t r;
        r = '{1'b0, inst, kind, alu, rs1, rs2, rd, imm, jt};
        tbl.push_back(r);
    endtask

    task automatic add_full_word(input logic [INST_W-1:0] inst);
        row_t r;
        r = '{1'b1, inst, K_NONE, ALU_ADD, 5'd0, 5'd0, 5'd0, 32'h0, 32'h0};
        tbl.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] seed;
        seed = 32'd65;
        repeat (RAND_WORDS) begin
            seed = lcg_next(seed);
            add_full_word({seed[30:17], 2'b11});  // quadrant 3
        end
        // reserved encodings
        add_row(16'h0000, K_NONE, ALU_ADD, 5'd0, 5'd0, 5'd0, 32'h0, 32'h0);
        add_row(16'h9002, K_NONE, ALU_ADD, 5'd0, 5'd0, 5'd0, 32'h0, 32'h0);
        add_row(16'h6001, K_NONE, ALU_ADD, 5'd0, 5'd0, 5'd0, 32'h0, 32'h0);
        add_row(16'h8000, K_NONE, ALU_ADD, 5'd0, 5'd0, 5'd0, 32'h0, 32'h0);
        // quadrant 0
        add_row(16'h1FE4, K_ADDI4SPN, ALU_ADD, 5'd2, 5'd0, 5'd9, 32'h0000_03FC, 32'h0);
        add_row(16'h0800, K_ADDI4SPN, ALU_ADD, 5'd2, 5'd0, 5'd8, 32'h0000_0010, 32'h0);
        add_row(16'h5DE8, K_LW, ALU_ADD, 5'd11, 5'd0, 5'd10, 32'h0000_007C, 32'h0);
        add_row(16'hC05C, K_SW, ALU_ADD, 5'd8, 5'd15, 5'd0, 32'h0000_0004, 32'h0);
        // quadrant 1
        add_row(16'h12F5, K_ADDI, ALU_ADD, 5'd5, 5'd0, 5'd5, 32'hFFFF_FFFD, 32'h0);
        add_row(16'h2FFD, K_JAL, ALU_ADD, 5'd0, 5'd0, 5'd1, 32'h0, 32'h0000_07FE);
        add_row(16'h3FF5, K_JAL, ALU_ADD, 5'd0, 5'd0, 5'd1, 32'h0, 32'hFFFF_FFFC);
        add_row(16'h467D, K_LI, ALU_ADD, 5'd0, 5'd0, 5'd12, 32'h0000_001F, 32'h0);
        add_row(16'h5081, K_LI, ALU_ADD, 5'd0, 5'd0, 5'd1, 32'hFFFF_FFE0, 32'h0);
        add_row(16'h61FD, K_LUI, ALU_ADD, 5'd0, 5'd0, 5'd3, 32'h0001_F000, 32'h0);
        add_row(16'h73FD, K_LUI, ALU_ADD, 5'd0, 5'd0, 5'd7, 32'hFFFF_F000, 32'h0);
        add_row(16'h7101, K_ADDI16SP, ALU_ADD, 5'd2, 5'd0, 5'd2, 32'hFFFF_FE00, 32'h0);
        add_row(16'h617D, K_ADDI16SP, ALU_ADD, 5'd2, 5'd0, 5'd2, 32'h0000_01F0, 32'h0);
        add_row(16'h8011, K_SRLI, ALU_SRL, 5'd8, 5'd0, 5'd8, 32'h0000_0004, 32'h0);
        add_row(16'h86FD, K_SRAI, ALU_SRA, 5'd13, 5'd0, 5'd13, 32'h0000_001F, 32'h0);
        add_row(16'h9B41, K_ANDI, ALU_AND, 5'd14, 5'd0, 5'd14, 32'hFFFF_FFF0, 32'h0);
        add_row(16'h8C05, K_SUB, ALU_SUB, 5'd8, 5'd9, 5'd8, 32'h0, 32'h0);
        add_row(16'h8D2D, K_XOR, ALU_XOR, 5'd10, 5'd11, 5'd10, 32'h0, 32'h0);
        add_row(16'h8E55, K_OR, ALU_OR, 5'd12, 5'd13, 5'd12, 32'h0, 32'h0);
        add_row(16'h8FF9, K_AND, ALU_AND, 5'd15, 5'd14, 5'd15, 32'h0, 32'h0);
        add_row(16'hB001, K_J, ALU_ADD, 5'd0, 5'd0, 5'd0, 32'h0, 32'hFFFF_F800);
        add_row(16'hBFFD, K_J, ALU_ADD, 5'd0, 5'd0, 5'd0, 32'h0, 32'hFFFF_FFFE);
        add_row(16'hCCFD, K_BEQZ, ALU_SUB, 5'd9, 5'd0, 5'd0, 32'h0, 32'h0000_00FE);
        add_row(16'hDC7D, K_BEQZ, ALU_SUB, 5'd8, 5'd0, 5'd0, 32'h0, 32'hFFFF_FFFE);
        add_row(16'hF101, K_BNEZ, ALU_SUB, 5'd10, 5'd0, 5'd0, 32'h0, 32'hFFFF_FF00);
        add_row(16'hE781, K_BNEZ, ALU_SUB, 5'd15, 5'd0, 5'd0, 32'h0, 32'h0000_0008);
        // quadrant 2
        add_row(16'h030E, K_SLLI, ALU_SLL, 5'd6, 5'd0, 5'd6, 32'h0000_0003, 32'h0);
        add_row(16'h5A7E, K_LWSP, ALU_ADD, 5'd2, 5'd0, 5'd20, 32'h0000_00FC, 32'h0);
        add_row(16'hC47E, K_SWSP, ALU_ADD, 5'd2, 5'd31, 5'd0, 32'h0000_0008, 32'h0);
        add_row(16'h8082, K_JR, ALU_ADD, 5'd1, 5'd0, 5'd0, 32'h0, 32'h0);
        add_row(16'h9282, K_JALR, ALU_ADD, 5'd5, 5'd0, 5'd1, 32'h0, 32'h0);
        add_row(16'h85CE, K_MV, ALU_ADD, 5'd0, 5'd19, 5'd11, 32'h0, 32'h0);
        add_row(16'h9246, K_ADD, ALU_ADD, 5'd4, 5'd17, 5'd4, 32'h0, 32'h0);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_reset_state();
        check_value("o_valid", 32'(o_valid), 32'd0);
        check_value("o_wr_en", 32'(o_wr_en), 32'd0);
        check_value("o_is_jump", 32'(o_is_jump), 32'd0);
        check_value("o_is_btype", 32'(o_is_btype), 32'd0);
        check_value("o_is_stype", 32'(o_is_stype), 32'd0);
        check_value("o_is_load", 32'(o_is_load), 32'd0);
        check_value("o_btype", 32'(o_btype), 32'd0);
        check_value("o_sel_op_a", 32'(o_sel_op_a), 32'd0);
        check_value("o_sel_op_b", 32'(o_sel_op_b), 32'd0);
        check_value("o_use_a", 32'(o_use_a), 32'd0);
        check_value("o_use_b", 32'(o_use_b), 32'd0);
        check_value("o_rs1", 32'(o_rs1), 32'd0);
        check_value("o_rs2", 32'(o_rs2), 32'd0);
        check_value("o_rd", 32'(o_rd), 32'd0);
        check_value("o_imm", o_imm, 32'd0);
        check_value("o_jt", o_jt, 32'd0);
    endtask

    task automatic check_row(input row_t r);
        logic      jump, branch, store, load, rr, link, lui, writes;
        imm_sel_t  exp_isel;
        data_sel_t exp_dsel;
        jump   = r.kind inside {K_JAL, K_J, K_JR, K_JALR};
        branch = r.kind inside {K_BEQZ, K_BNEZ};
        store  = r.kind inside {K_SW, K_SWSP};
        load   = r.kind inside {K_LW, K_LWSP};
        rr     = r.kind inside {K_SUB, K_XOR, K_OR, K_AND, K_MV, K_ADD};
        link   = r.kind inside {K_JR, K_JALR};
        lui    = (r.kind == K_LUI);
        writes = !(r.kind inside {K_NONE, K_SW, K_SWSP, K_BEQZ, K_BNEZ, K_JR});
        if (jump) exp_isel = IMM_J;
        else if (branch) exp_isel = IMM_B;
        else if (lui) exp_isel = IMM_U;
        else if (store) exp_isel = IMM_S;
        else exp_isel = IMM_I;
        if (link) exp_dsel = DATA_PC_LINK;
        else if (lui) exp_dsel = DATA_IMM;
        else if (load) exp_dsel = DATA_MEM;
        else exp_dsel = DATA_ALU;

        check_value("o_valid", 32'(o_valid), 32'd1);
        check_value("o_is_compressed", 32'(o_is_compressed), 32'(!r.full));
        if (r.full) begin
            check_value("o_wr_en", 32'(o_wr_en), 32'd0);
        end else begin
            check_value("o_alu_op", 32'(o_alu_op), 32'(r.alu));
            check_value("o_rs1", 32'(o_rs1), 32'(r.rs1));
            check_value("o_rs2", 32'(o_rs2), 32'(r.rs2));
            check_value("o_rd", 32'(o_rd), 32'(r.rd));
            check_value("o_imm", o_imm, r.imm);
            if (r.kind inside {K_JAL, K_J, K_BEQZ, K_BNEZ}) begin
                check_value("o_jt", o_jt, r.jt);
            end
            check_value("o_imm_select", 32'(o_imm_select), 32'(exp_isel));
            check_value("o_sel_data", 32'(o_sel_data), 32'(exp_dsel));
            check_value("o_sel_op_a", 32'(o_sel_op_a), 32'(!(lui || link)));
            check_value("o_sel_op_b", 32'(o_sel_op_b), 32'(!(rr || branch)));
            check_value("o_wr_en", 32'(o_wr_en), 32'(writes));
            check_value("o_is_jump", 32'(o_is_jump), 32'(jump));
            check_value("o_is_btype", 32'(o_is_btype), 32'(branch));
            check_value("o_is_stype", 32'(o_is_stype), 32'(store));
            check_value("o_is_load", 32'(o_is_load), 32'(load));
            check_value("o_btype", 32'(o_btype),
                        (r.kind == K_BEQZ) ? 32'd2 : (r.kind == K_BNEZ) ? 32'd1 : 32'd0);
            check_value("o_use_a", 32'(o_use_a), 32'(r.rs1 != REG_ZERO));
            check_value("o_use_b", 32'(o_use_b), 32'(r.rs2 != REG_ZERO));
        end
    endtask

    initial begin
        table_built = 1'b0;
        clk         = 1'b0;
        i_reset     = 1'b1;
        i_valid     = 1'b0;
        i_inst      = '0;
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        i_reset <= 1'b0;
        // row i goes in at this edge while row i-1 is checked
        for (int i = 0; i <= tbl.size(); i++) begin
            @(posedge clk);
            if (i < tbl.size()) begin
                i_valid <= 1'b1;
                i_inst  <= tbl[i].inst;
            end else begin
                i_valid <= 1'b0;
                i_inst  <= 16'hFFFF; // ignored while idle
            end
            @(negedge clk);
            if (i == 0) check_reset_state();
            else check_row(tbl[i-1]);
        end
        // idle cycle drops valid while data holds
        @(posedge clk);
        @(negedge clk);
        check_value("o_valid", 32'(o_valid), 32'd0);
        check_value("o_rd", 32'(o_rd), 32'(tbl[tbl.size()-1].rd));
        check_value("o_rs2", 32'(o_rs2), 32'(tbl[tbl.size()-1].rs2));
        check_value("o_is_compressed", 32'(o_is_compressed), 32'd1);
        $display("TEST OK");
        $finish;
    end

    initial begin
        wait (table_built);
        repeat (tbl.size() + RESET_CYCLES + 20) @(posedge clk);
        $display("timeout: the decoder test did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* list.f */
hdl/rvc_pkg.sv
hdl/rvc_kind_if.sv
hdl/rvc_classifier.sv
hdl/rvc_reg_select.sv
hdl/rvc_imm_gen.sv
hdl/rvc_decode_stage.sv
hdl/rvc_decoder_top.sv
tests/rvc_decoder_assertions.sv
tests/tb_rvc_decoder.sv

/* Makefile */
TOP = tb_rvc_decoder

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

# a run stopped by an assertion lacks the pass line and fails below
sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "TEST OK" sim.log
	@! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
